/* source/renas_mem_consts.svh */
`ifndef RENAS_MEM_CONSTS_SVH
`define RENAS_MEM_CONSTS_SVH

// ---------------------------------------------------------------------------
// main memory geometry
// ---------------------------------------------------------------------------

// word width of the sram and of the bus data
`define MEM_DATA_W 32

// sram depth in words
// index width follows as log2 of this
`define MEM_LINE 256

// first byte address that belongs to the memory
`define MEM_BASE 32'h0000_0400

// byte address bits below the word
// every transfer is one full aligned word
`define BYTE_OFFSET 2

`endif

/* source/ahb_bus_pkg.sv */
`include "renas_mem_consts.svh"

// ---------------------------------------------------------------------------
// bus side words of the ahb-like slave ports
// ---------------------------------------------------------------------------
package ahb_bus_pkg;

  // byte address as driven by the master
  // full 32-bit space, only a small window maps to the memory
  typedef logic [31:0] haddr_t;

  // read and write data word
  // same width as an sram word, so the sram reuses it
  typedef logic [`MEM_DATA_W-1:0] hdata_t;

endpackage

/* source/mem_map_pkg.sv */
`include "renas_mem_consts.svh"

// ---------------------------------------------------------------------------
// address map and port sequencing shared by both slave ports
// ---------------------------------------------------------------------------
package mem_map_pkg;
  import ahb_bus_pkg::*;

  // word index into the sram
  typedef logic [$clog2(`MEM_LINE)-1:0] word_idx_t;

  // per transfer sequence of a port controller
  // idle -> access (sram enabled) -> read (data registered) -> resp
  typedef enum logic [1:0]
  {
    port_idle,
    port_access,
    port_read,
    port_resp
  } port_state_t;

  // map a bus byte address onto a word of the sram
  // returns 1 only for an aligned address inside the window
  function automatic logic decode_addr
  (
    input  haddr_t    addr,
    output word_idx_t idx
  );
    haddr_t offset;
    logic   aligned;
    logic   in_range;
    offset   = addr - `MEM_BASE;
    aligned  = (addr[`BYTE_OFFSET-1:0] == '0);
    // below base wraps to a huge offset and fails the range test
    in_range = (offset < (`MEM_LINE << `BYTE_OFFSET));
    idx      = word_idx_t'(offset >> `BYTE_OFFSET);
    return aligned && in_range;
  endfunction

endpackage

/* source/dual_port_sram.sv */
`timescale 1ns/1ps
`include "renas_mem_consts.svh"

module dual_port_sram
#(
  parameter int DEPTH = `MEM_LINE
)
(
  input  logic                   clk_l2,
  // read-only port, fetch side
  input  logic                   rd_en,
  input  mem_map_pkg::word_idx_t rd_addr,
  output ahb_bus_pkg::hdata_t    rd_data,
  // read/write port, data side
  input  logic                   rw_en,
  input  logic                   rw_we,
  input  mem_map_pkg::word_idx_t rw_addr,
  input  ahb_bus_pkg::hdata_t    rw_wdata,
  output ahb_bus_pkg::hdata_t    rw_rdata
);
  import ahb_bus_pkg::*;

  // word array
  // contents are undefined until written
  hdata_t mem [DEPTH];

  // ---------------------------------------------------------------------------
  // read port
  // ---------------------------------------------------------------------------
  // registered output, holds while disabled
  always_ff @(posedge clk_l2)
  begin
    if (rd_en)
      rd_data <= mem[rd_addr];
  end

  // ---------------------------------------------------------------------------
  // read/write port
  // ---------------------------------------------------------------------------
  // nonblocking update gives read-first on both ports
  // a same-edge read of the written word sees the old value
  always_ff @(posedge clk_l2)
  begin
    if (rw_en)
    begin
      if (rw_we)
        mem[rw_addr] <= rw_wdata;
      rw_rdata <= mem[rw_addr];
    end
  end

endmodule

/* source/fetch_port.sv */
`timescale 1ns/1ps

module fetch_port
(
  input  logic                   clk_l2,
  input  logic                   rst_n,
  // slave side of the fetch bus
  input  logic                   hsel,
  input  ahb_bus_pkg::haddr_t    haddr,
  output logic                   hreadyout,
  output logic                   hresp,
  output ahb_bus_pkg::hdata_t    hrdata,
  // sram read port
  output logic                   rd_en,
  output mem_map_pkg::word_idx_t rd_addr,
  input  ahb_bus_pkg::hdata_t    rd_data
);
  import mem_map_pkg::*;

  port_state_t state;

  // decode of the live address
  word_idx_t dec_idx;
  logic      dec_ok;

  // captured transfer
  word_idx_t idx_q;
  logic      valid_q;

  always_comb
  begin
    dec_ok = decode_addr(haddr, dec_idx);
  end

  // ---------------------------------------------------------------------------
  // transfer sequencing
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_l2 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= port_idle;
      valid_q   <= 1'b0;
      hreadyout <= 1'b0;
      hresp     <= 1'b0;
      hrdata    <= '0;
    end
    else
    begin
      case (state)
        // E0, sample select and keep decode result
        port_idle:
        begin
          if (hsel)
          begin
            valid_q <= dec_ok;
            state   <= port_access;
          end
        end
        // E1, sram clocked when valid
        port_access:
          state <= port_read;
        // E2, hand registered word to the bus
        port_read:
        begin
          hreadyout <= 1'b1;
          hresp     <= !valid_q;
          hrdata    <= valid_q ? rd_data : '0;
          state     <= port_resp;
        end
        // E3, end of pulse, hsel ignored here
        port_resp:
        begin
          hreadyout <= 1'b0;
          hresp     <= 1'b0;
          hrdata    <= '0;
          state     <= port_idle;
        end
      endcase
    end
  end

  // word index of the accepted fetch
  always_ff @(posedge clk_l2)
  begin
    if ((state == port_idle) && hsel)
      idx_q <= dec_idx;
  end

  // sram read only for a good address
  assign rd_en   = (state == port_access) && valid_q;
  assign rd_addr = idx_q;

endmodule

/* source/data_port.sv */
`timescale 1ns/1ps

module data_port
(
  input  logic                   clk_l2,
  input  logic                   rst_n,
  // slave side of the data bus
  input  logic                   hsel,
  input  logic                   hwrite,
  input  ahb_bus_pkg::haddr_t    haddr,
  input  ahb_bus_pkg::hdata_t    hwdata,
  output logic                   hreadyout,
  output logic                   hresp,
  output ahb_bus_pkg::hdata_t    hrdata,
  // sram read/write port
  output logic                   rw_en,
  output logic                   rw_we,
  output mem_map_pkg::word_idx_t rw_addr,
  output ahb_bus_pkg::hdata_t    rw_wdata,
  input  ahb_bus_pkg::hdata_t    rw_rdata
);
  import ahb_bus_pkg::*;
  import mem_map_pkg::*;

  port_state_t state;

  // decode of the live address
  word_idx_t dec_idx;
  logic      dec_ok;

  // captured transfer, control part
  logic valid_q;
  logic write_q;

  // captured transfer, payload part
  word_idx_t idx_q;
  hdata_t    wdata_q;

  always_comb
  begin
    dec_ok = decode_addr(haddr, dec_idx);
  end

  // ---------------------------------------------------------------------------
  // transfer sequencing
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_l2 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= port_idle;
      valid_q   <= 1'b0;
      write_q   <= 1'b0;
      hreadyout <= 1'b0;
      hresp     <= 1'b0;
      hrdata    <= '0;
    end
    else
    begin
      case (state)
        // E0, accept and remember direction
        port_idle:
        begin
          if (hsel)
          begin
            valid_q <= dec_ok;
            write_q <= hwrite;
            state   <= port_access;
          end
        end
        // E1, store lands here on a good write
        port_access:
          state <= port_read;
        // E2, response pulse
        // load gets the word, store and error get zero
        port_read:
        begin
          hreadyout <= 1'b1;
          hresp     <= !valid_q;
          hrdata    <= (valid_q && !write_q) ? rw_rdata : '0;
          state     <= port_resp;
        end
        // E3, back to idle, no sample this edge
        port_resp:
        begin
          hreadyout <= 1'b0;
          hresp     <= 1'b0;
          hrdata    <= '0;
          state     <= port_idle;
        end
      endcase
    end
  end

  // address and write word of the accepted transfer
  always_ff @(posedge clk_l2)
  begin
    if ((state == port_idle) && hsel)
    begin
      idx_q   <= dec_idx;
      wdata_q <= hwdata;
    end
  end

  // ---------------------------------------------------------------------------
  // sram side
  // ---------------------------------------------------------------------------
  // bad address never touches the array
  assign rw_en    = (state == port_access) && valid_q;
  assign rw_we    = rw_en && write_q;
  assign rw_addr  = idx_q;
  assign rw_wdata = wdata_q;

endmodule

/* source/renas_memory.sv */
`timescale 1ns/1ps
`include "renas_mem_consts.svh"

module renas_memory
(
  // fetch port, read only
  input  logic                imem_hsel,
  input  ahb_bus_pkg::haddr_t imem_haddr,
  output logic                imem_hreadyout,
  output logic                imem_hresp,
  output ahb_bus_pkg::hdata_t imem_hrdata,
  // data port, loads and stores
  input  logic                dmem_hsel,
  input  ahb_bus_pkg::haddr_t dmem_haddr,
  input  logic                dmem_hwrite,
  input  ahb_bus_pkg::hdata_t dmem_hwdata,
  output logic                dmem_hreadyout,
  output logic                dmem_hresp,
  output ahb_bus_pkg::hdata_t dmem_hrdata,
  // system
  input  logic                clk_l2,
  input  logic                rst_n
);
  import ahb_bus_pkg::*;
  import mem_map_pkg::*;

  // ---------------------------------------------------------------------------
  // port to sram wires
  // ---------------------------------------------------------------------------
  // fetch side
  logic      rd_en;
  word_idx_t rd_addr;
  hdata_t    rd_data;

  // data side
  logic      rw_en;
  logic      rw_we;
  word_idx_t rw_addr;
  hdata_t    rw_wdata;
  hdata_t    rw_rdata;

  fetch_port fetch_i
  (
    .clk_l2    (clk_l2),
    .rst_n     (rst_n),
    .hsel      (imem_hsel),
    .haddr     (imem_haddr),
    .hreadyout (imem_hreadyout),
    .hresp     (imem_hresp),
    .hrdata    (imem_hrdata),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  data_port data_i
  (
    .clk_l2    (clk_l2),
    .rst_n     (rst_n),
    .hsel      (dmem_hsel),
    .hwrite    (dmem_hwrite),
    .haddr     (dmem_haddr),
    .hwdata    (dmem_hwdata),
    .hreadyout (dmem_hreadyout),
    .hresp     (dmem_hresp),
    .hrdata    (dmem_hrdata),
    .rw_en     (rw_en),
    .rw_we     (rw_we),
    .rw_addr   (rw_addr),
    .rw_wdata  (rw_wdata),
    .rw_rdata  (rw_rdata)
  );

  // one shared array, fetch on the read port
  dual_port_sram #(.DEPTH(`MEM_LINE)) sram_i
  (
    .clk_l2   (clk_l2),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rw_en    (rw_en),
    .rw_we    (rw_we),
    .rw_addr  (rw_addr),
    .rw_wdata (rw_wdata),
    .rw_rdata (rw_rdata)
  );

endmodule

/* tests/mem_checker.sv */
`timescale 1ns/1ps
`include "renas_mem_consts.svh"

module mem_checker
(
  input logic                clk_l2,
  input logic                rst_n,
  // fetch port
  input logic                imem_hsel,
  input ahb_bus_pkg::haddr_t imem_haddr,
  input logic                imem_hreadyout,
  input logic                imem_hresp,
  input ahb_bus_pkg::hdata_t imem_hrdata,
  // data port
  input logic                dmem_hsel,
  input ahb_bus_pkg::haddr_t dmem_haddr,
  input logic                dmem_hwrite,
  input ahb_bus_pkg::hdata_t dmem_hwdata,
  input logic                dmem_hreadyout,
  input logic                dmem_hresp,
  input ahb_bus_pkg::hdata_t dmem_hrdata
);
  import ahb_bus_pkg::*;

  // reference copy of the sram
  hdata_t model [`MEM_LINE];
  int     checks = 0;
  int     errors = 0;

  // edges since the sampling edge, 0 is idle
  int         f_step = 0;
  int         d_step = 0;
  logic       f_ok, d_ok, d_wr;
  logic [7:0] f_idx, d_idx;
  hdata_t     d_wdata, f_exp, d_exp;

  // aligned and inside the window, index counted from the base
  function automatic logic word_of(input haddr_t a, output logic [7:0] idx);
    haddr_t rel;
    rel = a - `MEM_BASE;
    idx = rel[9:2];
    return (a[1:0] == 2'b00) && (a >= `MEM_BASE) && (rel < (`MEM_LINE << `BYTE_OFFSET));
  endfunction

  task automatic compare(input string name, input hdata_t exp, input hdata_t act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // --------------------------------------------------------------------------
  // compare first, then advance the model
  // --------------------------------------------------------------------------
  always @(posedge clk_l2)
  begin
    if (!rst_n)
    begin
      f_step = 0;
      d_step = 0;
    end
    else
    begin
      // pulse only in the cycle after E2, zero everywhere else
      compare("imem_hreadyout", 32'(f_step == 3), 32'(imem_hreadyout));
      compare("imem_hresp", 32'(f_step == 3 && !f_ok), 32'(imem_hresp));
      compare("imem_hrdata", (f_step == 3) ? f_exp : '0, imem_hrdata);
      compare("dmem_hreadyout", 32'(d_step == 3), 32'(dmem_hreadyout));
      compare("dmem_hresp", 32'(d_step == 3 && !d_ok), 32'(dmem_hresp));
      compare("dmem_hrdata", (d_step == 3) ? d_exp : '0, dmem_hrdata);
      // fetch handled before data, same-edge store stays unseen
      case (f_step)
        0:
          if (imem_hsel)
          begin
            f_ok   = word_of(imem_haddr, f_idx);
            f_step = 1;
          end
        1:
        begin
          f_exp  = f_ok ? model[f_idx] : '0;
          f_step = 2;
        end
        default:
          f_step = (f_step + 1) % 4;
      endcase
      case (d_step)
        0:
          if (dmem_hsel)
          begin
            d_ok    = word_of(dmem_haddr, d_idx);
            d_wr    = dmem_hwrite;
            d_wdata = dmem_hwdata;
            d_step  = 1;
          end
        // E1, store lands, load takes the old word
        1:
        begin
          d_exp = (d_ok && !d_wr) ? model[d_idx] : '0;
          if (d_ok && d_wr)
            model[d_idx] = d_wdata;
          d_step = 2;
        end
        default:
          d_step = (d_step + 1) % 4;
      endcase
    end
  end

endmodule

/* tests/tb_renas_memory.sv */
`timescale 1ns/1ps
`include "renas_mem_consts.svh"

module tb_renas_memory;
  import ahb_bus_pkg::*;

  localparam logic [31:0] SEED = 32'd94578;
  localparam int N_PAIR = 32;
  localparam int N_COLL = 16;
  localparam int N_BAD  = 16;
  localparam int N_RAND = 200;
  localparam int N_XFER = `MEM_LINE + 4 * N_PAIR + 2 * N_COLL + 3 * N_BAD + 2 * N_RAND;
  // every transfer plus its gap fits in 8 cycles
  localparam int LIMIT  = N_XFER * 8 + 100;

  logic   clk_l2, rst_n;
  logic   imem_hsel, imem_hreadyout, imem_hresp;
  haddr_t imem_haddr;
  hdata_t imem_hrdata;
  logic   dmem_hsel, dmem_hwrite, dmem_hreadyout, dmem_hresp;
  haddr_t dmem_haddr;
  hdata_t dmem_hwdata, dmem_hrdata;
  logic [31:0] rng;
  int     err_mark = 0;

  renas_memory dut_i (.*);
  mem_checker chk_i (.*);

  initial
  begin
    clk_l2 = 1'b0;
    forever #5 clk_l2 = ~clk_l2;
  end

  // watchdog
  initial
  begin
    repeat (LIMIT) @(posedge clk_l2);
    $display("timeout: transfers not finished after %0d cycles", LIMIT);
    $display("sim failed");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic haddr_t good_addr(input logic [7:0] idx);
    return `MEM_BASE + {22'b0, idx, 2'b00};
  endfunction

  // below base, past the end, or misaligned inside
  function automatic haddr_t bad_addr(input logic [31:0] r);
    case (r[1:0])
      2'd0:    return {22'b0, r[15:8], 2'b00};
      2'd1:    return `MEM_BASE + (`MEM_LINE << `BYTE_OFFSET) + {22'b0, r[15:8], 2'b00};
      default: return good_addr(r[15:8]) | {30'b0, r[17], 1'b1};
    endcase
  endfunction

  // roughly 1 in 8 addresses is bad
  function automatic haddr_t pick_addr(input logic [31:0] r);
    return (r[31:29] == 3'd0) ? bad_addr(r) : good_addr(r[15:8]);
  endfunction

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk_l2);
      #1;
    end
  endtask

  // hold until hreadyout seen at an edge, then release
  task automatic fetch_read(input haddr_t a);
    imem_hsel  = 1'b1;
    imem_haddr = a;
    do idle(1); while (!imem_hreadyout);
    idle(1);
    imem_hsel = 1'b0;
  endtask

  task automatic data_xfer(input logic wr, input haddr_t a, input hdata_t d);
    dmem_hsel   = 1'b1;
    dmem_hwrite = wr;
    dmem_haddr  = a;
    dmem_hwdata = d;
    do idle(1); while (!dmem_hreadyout);
    idle(1);
    dmem_hsel = 1'b0;
  endtask

  task automatic fetch_traffic(input logic [31:0] s);
    for (int i = 0; i < N_RAND; i++)
    begin
      s = xorshift(s);
      idle(int'(s[25:24]));
      fetch_read(pick_addr(s));
    end
  endtask

  task automatic data_traffic(input logic [31:0] s);
    for (int i = 0; i < N_RAND; i++)
    begin
      s = xorshift(s);
      idle(int'(s[25:24]));
      data_xfer(s[20], pick_addr(s), xorshift(s));
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d errors", name, chk_i.errors - err_mark);
    err_mark = chk_i.errors;
  endtask

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------
  initial
  begin
    rst_n = 1'b0;
    imem_hsel = 1'b0;
    imem_haddr = '0;
    dmem_hsel = 1'b0;
    dmem_hwrite = 1'b0;
    dmem_haddr = '0;
    dmem_hwdata = '0;
    rng = SEED;
    repeat (5) @(posedge clk_l2);
    #1;
    rst_n = 1'b1;
    idle(4);
    end_test("reset");
    // fill every word so later reads are defined
    for (int i = 0; i < `MEM_LINE; i++)
    begin
      rng = xorshift(rng);
      data_xfer(1'b1, good_addr(8'(i)), rng);
    end
    for (int i = 0; i < N_PAIR; i++)
    begin
      rng = xorshift(rng);
      data_xfer(1'b1, good_addr(rng[15:8]), xorshift(rng));
      data_xfer(1'b0, good_addr(rng[15:8]), '0);
    end
    end_test("store then load");
    for (int i = 0; i < N_PAIR; i++)
    begin
      rng = xorshift(rng);
      data_xfer(1'b1, good_addr(rng[15:8]), xorshift(rng));
      fetch_read(good_addr(rng[15:8]));
    end
    // same sampling edge, so same E1 on both ports
    for (int i = 0; i < N_COLL; i++)
    begin
      rng = xorshift(rng);
      fork
        data_xfer(1'b1, good_addr(rng[15:8]), ~rng);
        fetch_read(good_addr(rng[15:8]));
      join
    end
    end_test("fetch sees data writes");
    for (int i = 0; i < N_BAD; i++)
    begin
      rng = xorshift(rng);
      data_xfer(1'b1, bad_addr(rng), ~rng);
      data_xfer(1'b0, good_addr(rng[15:8]), '0);
      fetch_read(bad_addr(xorshift(rng)));
    end
    end_test("address errors");
    fork
      fetch_traffic(rng ^ 32'h5a5a_0f0f);
      data_traffic(rng);
    join
    end_test("concurrent traffic");
    $display("passed %0d checks, failed %0d", chk_i.checks - chk_i.errors, chk_i.errors);
    if (chk_i.errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+source
source/ahb_bus_pkg.sv
source/mem_map_pkg.sv
source/dual_port_sram.sv
source/fetch_port.sv
source/data_port.sv
source/renas_memory.sv
tests/mem_checker.sv
tests/tb_renas_memory.sv

/* run_sim.sh */
#!/bin/sh
# build the memory testbench with verilator and run it into sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_renas_memory -f filelist.f -o sim_renas \
  && ./obj_dir/sim_renas > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && { echo "simulation reported failure"; exit 1; }
echo "simulation clean"
exit 0
